//--- all.f
verilog/vidPkg.sv
verilog/vidTimingIf.sv
verilog/vidTimingGen.sv
verilog/patternGen.sv
verilog/dacOutStage.sv
verilog/vgaSubsystem.sv
test/tb_vgaSubsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the VGA subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_vgaSubsystem
LOG=sim.log

rm -f "$LOG"

verilator --binary --timing --timescale 1ns/1ps --top-module "$TOP" \
    -Mdir obj_dir -f all.f \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/V"$TOP" > "$LOG" 2>&1 || echo "simulation exited with an error status"
cat "$LOG"

grep -q "Testbench failed" "$LOG" && { echo "RESULT: FAIL"; exit 1; }
grep -q "Testbench passed" "$LOG" || { echo "RESULT: FAIL (no result line)"; exit 1; }
echo "RESULT: PASS"
exit 0

//--- test/tb_vgaSubsystem.sv
`default_nettype none

module tb_vgaSubsystem;

    timeunit 1ns;
    timeprecision 1ps;

    // small raster, 25 x 13 pixels including blanking
    localparam int HorActive      = 16;
    localparam int HorFrontPorch  = 2;
    localparam int HorSync        = 4;
    localparam int HorBackPorch   = 3;
    localparam int VertActive     = 8;
    localparam int VertFrontPorch = 1;
    localparam int VertSync       = 2;
    localparam int VertBackPorch  = 2;

    localparam int HorTotal    = HorActive + HorFrontPorch + HorSync + HorBackPorch;
    localparam int VertTotal   = VertActive + VertFrontPorch + VertSync + VertBackPorch;
    localparam int FrameCycles = HorTotal * VertTotal;
    localparam int ActiveLineCycles = HorTotal * VertActive;
    localparam int HSyncStart  = HorActive + HorFrontPorch;
    localparam int HSyncEnd    = HSyncStart + HorSync;
    localparam int VSyncStart  = VertActive + VertFrontPorch;
    localparam int VSyncEnd    = VSyncStart + VertSync;
    localparam int BarWidth    = HorActive / 8;
    localparam int Latency     = 3;          // counters to DAC pins
    localparam int ClkPeriod   = 8;
    localparam int MaxTests    = 64;
    localparam logic [31:0] Seed = 32'ha10d;

    logic        i_VidClk;
    logic        i_arstN;
    logic [1:0]  i_PatMode;
    logic [15:0] i_SolidColour;
    logic [15:0] i_Colour;
    logic [10:0] o_HPos;
    logic [10:0] o_VPos;
    logic [4:0]  o_R;
    logic [5:0]  o_G;
    logic [4:0]  o_B;
    logic        o_nBlank;
    logic        o_HSync;
    logic        o_VSync;
    logic        o_InVBlank;

    logic [15:0] stimMem [0:MaxTests*3-1];   // mode, solid colour, first pixel
    int          numTests;
    int          errors;
    logic        stimLoaded;

    int               hPos;                  // output pixel now on the pins
    int               vPos;
    vidPkg::patMode_e curMode;               // mode the DUT shows this frame
    logic [15:0]      curSolid;
    vidPkg::patMode_e newMode;               // mode the DUT takes at the next frame start
    logic [15:0]      newSolid;
    vidPkg::patMode_e tbMode;                // mode driven on the inputs
    logic [15:0]      tbSolid;
    logic             vSyncWas;
    logic             vSyncRise;

    vgaSubsystem #(
        .HorActive      (HorActive),
        .HorFrontPorch  (HorFrontPorch),
        .HorSync        (HorSync),
        .HorBackPorch   (HorBackPorch),
        .VertActive     (VertActive),
        .VertFrontPorch (VertFrontPorch),
        .VertSync       (VertSync),
        .VertBackPorch  (VertBackPorch)
    ) dut0 (
        .i_VidClk      (i_VidClk),
        .i_arstN       (i_arstN),
        .i_PatMode     (i_PatMode),
        .i_SolidColour (i_SolidColour),
        .i_Colour      (i_Colour),
        .o_HPos        (o_HPos),
        .o_VPos        (o_VPos),
        .o_R           (o_R),
        .o_G           (o_G),
        .o_B           (o_B),
        .o_nBlank      (o_nBlank),
        .o_HSync       (o_HSync),
        .o_VSync       (o_VSync),
        .o_InVBlank    (o_InVBlank)
    );

    initial begin
        i_VidClk = 1'b0;
        forever #(ClkPeriod / 2) i_VidClk = ~i_VidClk;
    end

    // pseudo frame store, one LCG step on the position
    function automatic logic [15:0] frameStoreColour(input logic [10:0] v, input logic [10:0] h);
        logic [31:0] state;
        state = Seed ^ {10'd0, v, h};
        state = state * 32'd1664525 + 32'd1013904223;
        return state[31:16];
    endfunction

    // frame store answers one cycle after the position
    initial begin
        i_Colour = 16'h0000;
        forever begin
            @(posedge i_VidClk);
            i_Colour <= frameStoreColour(o_VPos, o_HPos);
        end
    end

    function automatic logic [15:0] expectedColour(input vidPkg::patMode_e mode,
                                                   input logic [15:0] solid,
                                                   input int h, input int v);
        logic [15:0] colour;
        case (mode)
            vidPkg::patSolid:      colour = solid;
            vidPkg::patColourBars: colour = vidPkg::BarColours[3'(h / BarWidth)];
            vidPkg::patGradient:   colour = {5'(h % 32), 6'(v % 64), 5'((h + v) % 32)};
            default:               colour = frameStoreColour(11'(v), 11'(h));
        endcase
        return colour;
    endfunction

    task automatic compareValue(input string name, input logic [15:0] actual,
                                input logic [15:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0d ns: %s is %h, expected %h",
                     $time, name, actual, expected);
            $display("Testbench failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic checkBlankOutputs();
        compareValue("o_nBlank", 16'(o_nBlank), 16'h0);
        compareValue("o_HSync", 16'(o_HSync), 16'h0);
        compareValue("o_VSync", 16'(o_VSync), 16'h0);
        compareValue("o_InVBlank", 16'(o_InVBlank), 16'h0);
        compareValue("o_RGB", {o_R, o_G, o_B}, 16'h0);
    endtask

    task automatic checkPixel(input int h, input int v);
        logic        active;
        logic [15:0] colour;
        int          rawIdx;
        active = (h < HorActive) && (v < VertActive);
        colour = active ? expectedColour(curMode, curSolid, h, v) : 16'h0000;
        // the counters run ahead of the DAC pins by the pipeline depth
        rawIdx = (v * HorTotal + h + Latency) % FrameCycles;
        compareValue("o_HPos", 16'(o_HPos), 16'(rawIdx % HorTotal));
        compareValue("o_VPos", 16'(o_VPos), 16'(rawIdx / HorTotal));
        compareValue("o_nBlank", 16'(o_nBlank), 16'(active));
        compareValue("o_HSync", 16'(o_HSync), 16'(h >= HSyncStart && h < HSyncEnd));
        compareValue("o_VSync", 16'(o_VSync), 16'(v >= VSyncStart && v < VSyncEnd));
        compareValue("o_InVBlank", 16'(o_InVBlank), 16'(v >= VertActive));
        compareValue("o_R", 16'(o_R), 16'(colour[15:11]));
        compareValue("o_G", 16'(o_G), 16'(colour[10:5]));
        compareValue("o_B", 16'(o_B), 16'(colour[4:0]));
    endtask

    // check one output pixel, optionally drive a new mode, step the tracked position
    task automatic runPixel(input logic applyMode);
        checkPixel(hPos, vPos);
        @(posedge i_VidClk);
        if (applyMode) begin
            i_PatMode     <= tbMode;
            i_SolidColour <= tbSolid;
        end
        @(negedge i_VidClk);
        hPos++;
        if (hPos == HorTotal) begin
            hPos = 0;
            vPos = (vPos == VertTotal - 1) ? 0 : vPos + 1;
        end
        if (hPos == 0 && vPos == 0) begin
            curMode  = newMode;   // latched at the raw frame start, long before this
            curSolid = newSolid;
        end
    endtask

    task automatic loadStimulus();
        $readmemh("test/vga_stimulus.txt", stimMem);
        numTests = 0;
        while (numTests < MaxTests && stimMem[3*numTests] != 16'hFFFF) begin
            numTests++;
        end
    endtask

    initial begin
        i_arstN       = 1'b0;
        i_PatMode     = 2'd0;
        i_SolidColour = 16'h0000;
        errors        = 0;
        stimLoaded    = 1'b0;
        tbMode        = vidPkg::patSolid;
        tbSolid       = 16'h0000;
        newMode       = vidPkg::patSolid;
        newSolid      = 16'h0000;
        curMode       = vidPkg::patSolid;
        curSolid      = 16'h0000;
        loadStimulus();
        if (numTests == 0 || numTests == MaxTests) begin
            $display("stimulus file is missing, empty or has no end marker");
            $display("Testbench failed");
            $fatal(1, "no usable stimulus");
        end
        stimLoaded = 1'b1;

        repeat (3) @(posedge i_VidClk);
        @(negedge i_VidClk);
        checkBlankOutputs();
        @(posedge i_VidClk);
        i_arstN <= 1'b1;

        // pipeline still holds reset values until pixel 0,0 arrives
        @(negedge i_VidClk);
        while (!o_nBlank) begin
            checkBlankOutputs();
            @(negedge i_VidClk);
        end
        hPos = 0;
        vPos = 0;

        for (int t = 0; t < numTests; t++) begin
            vSyncRise = 1'b0;
            while (!vSyncRise) begin
                vSyncWas = o_VSync;
                runPixel(1'b0);
                vSyncRise = o_VSync && !vSyncWas;
            end
            newMode  = vidPkg::patMode_e'(stimMem[3*t][1:0]);
            newSolid = stimMem[3*t+1];
            tbMode   = newMode;
            tbSolid  = newSolid;
            runPixel(1'b1);
            // old frame finishes its blanking lines
            while (!(hPos == 0 && vPos == 0)) begin
                runPixel(1'b0);
            end
            compareValue("first pixel", {o_R, o_G, o_B}, stimMem[3*t+2]);
            // other inputs during the visible lines must not reach this frame
            tbMode  = vidPkg::patMode_e'(2'(newMode + 2'd1));
            tbSolid = ~newSolid;
            runPixel(1'b1);
            repeat (ActiveLineCycles - 1) runPixel(1'b0);
            tbMode  = newMode;    // back before the next frame start
            tbSolid = newSolid;
            runPixel(1'b1);
            repeat (FrameCycles - ActiveLineCycles - 1) runPixel(1'b0);
        end

        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog, each test needs about two frames
    initial begin
        wait (stimLoaded);
        #((numTests + 3) * FrameCycles * ClkPeriod * 2);
        $display("timeout: frame checks did not complete for %0d tests", numTests);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- test/vga_stimulus.txt
// columns: pattern mode (0 solid, 1 bars, 2 gradient, 3 external), solid colour,
// expected RGB565 of the first visible pixel; a line of ffff ends the list
0 F800 F800 // solid red
1 0000 FFFF // bars start with white
2 0000 0000 // gradient at pixel 0,0
3 0000 36E7 // frame store colour of pixel 0,0
0 07E0 07E0 // solid green
0 001F 001F // solid blue
2 1234 0000 // solid colour ignored
1 ABCD FFFF
3 5555 36E7
0 FFFF FFFF // solid white
1 0000 FFFF // same mode twice in a row
1 0000 FFFF
0 A5A5 A5A5
3 0000 36E7
2 FFFF 0000
0 0000 0000 // back to black
1 F81F FFFF
0 7BEF 7BEF // mid grey
3 FFFF 36E7
2 0000 0000
ffff ffff ffff

//--- verilog/dacOutStage.sv
`default_nettype none

module dacOutStage (
    input wire logic            i_VidClk,
    input wire logic            i_arstN,
    vidTimingIf.sink            i_Timing,
    input wire vidPkg::rgb565_t i_Colour,
    output logic [4:0]          o_R,
    output logic [5:0]          o_G,
    output logic [4:0]          o_B,
    output logic                o_nBlank,    // low forces the DAC to blank level
    output logic                o_HSync,
    output logic                o_VSync,
    output logic                o_InVBlank
);

    // every pin changes on the same edge so the DAC sees one pixel at a time
    always_ff @(posedge i_VidClk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_R        <= '0;
            o_G        <= '0;
            o_B        <= '0;
            o_nBlank   <= 1'b0;
            o_HSync    <= 1'b0;
            o_VSync    <= 1'b0;
            o_InVBlank <= 1'b0;
        end else begin
            o_nBlank   <= i_Timing.active;
            o_HSync    <= i_Timing.hSync;
            o_VSync    <= i_Timing.vSync;
            o_InVBlank <= i_Timing.inVBlank;
            if (i_Timing.active) begin
                o_R <= i_Colour.red;
                o_G <= i_Colour.green;
                o_B <= i_Colour.blue;
            end else begin
                // black outside the visible area
                o_R <= '0;
                o_G <= '0;
                o_B <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/patternGen.sv
`default_nettype none

module patternGen #(
    parameter int HorActive = 640
) (
    input wire logic             i_VidClk,
    input wire logic             i_arstN,
    vidTimingIf.sink             i_Timing,
    vidTimingIf.timing           o_Timing,
    input wire vidPkg::patMode_e i_PatMode,
    input wire vidPkg::rgb565_t  i_SolidColour,
    input wire vidPkg::rgb565_t  i_Colour,       // one cycle after the position
    output vidPkg::rgb565_t      o_Colour
);

    localparam int W = vidPkg::PosWidth;

    // each of the eight bars is this many pixels wide
    localparam logic [W-1:0] BarWidth = W'(HorActive / 8);

    // stage 1 copy of the timing bundle
    logic [W-1:0] s1HPos;
    logic [W-1:0] s1VPos;
    logic         s1Active;
    logic         s1HSync;
    logic         s1VSync;
    logic         s1InVBlank;
    logic         s1FrameStart;

    vidPkg::patMode_e patMode;      // held for a whole frame
    vidPkg::rgb565_t  solidColour;

    logic [2:0]       barIdx;
    logic [W-1:0]     gradSum;
    vidPkg::rgb565_t  nextColour;

    // stage 1 flags, plus the per-frame mode latch
    always_ff @(posedge i_VidClk or negedge i_arstN) begin
        if (!i_arstN) begin
            s1Active     <= 1'b0;
            s1HSync      <= 1'b0;
            s1VSync      <= 1'b0;
            s1InVBlank   <= 1'b0;
            s1FrameStart <= 1'b0;
            patMode      <= vidPkg::patSolid;
            solidColour  <= '0;
        end else begin
            s1Active     <= i_Timing.active;
            s1HSync      <= i_Timing.hSync;
            s1VSync      <= i_Timing.vSync;
            s1InVBlank   <= i_Timing.inVBlank;
            s1FrameStart <= i_Timing.frameStart;
            if (i_Timing.frameStart) begin
                patMode     <= i_PatMode;
                solidColour <= i_SolidColour;
            end
        end
    end

    always_ff @(posedge i_VidClk) begin
        s1HPos <= i_Timing.hPos;
        s1VPos <= i_Timing.vPos;
    end

    // colour for the stage 1 pixel
    always_comb begin
        barIdx     = 3'(s1HPos / BarWidth);
        gradSum    = s1HPos + s1VPos;
        nextColour = solidColour;
        case (patMode)
            vidPkg::patSolid:      nextColour = solidColour;
            vidPkg::patColourBars: nextColour = vidPkg::BarColours[barIdx];
            vidPkg::patGradient: begin
                nextColour.red   = s1HPos[4:0];
                nextColour.green = s1VPos[5:0];
                nextColour.blue  = gradSum[4:0];
            end
            vidPkg::patExternal:   nextColour = i_Colour;
            default:               nextColour = solidColour;
        endcase
    end

    // stage 2, bundle and colour leave together
    always_ff @(posedge i_VidClk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_Timing.active     <= 1'b0;
            o_Timing.hSync      <= 1'b0;
            o_Timing.vSync      <= 1'b0;
            o_Timing.inVBlank   <= 1'b0;
            o_Timing.frameStart <= 1'b0;
        end else begin
            o_Timing.active     <= s1Active;
            o_Timing.hSync      <= s1HSync;
            o_Timing.vSync      <= s1VSync;
            o_Timing.inVBlank   <= s1InVBlank;
            o_Timing.frameStart <= s1FrameStart;
        end
    end

    always_ff @(posedge i_VidClk) begin
        o_Timing.hPos <= s1HPos;
        o_Timing.vPos <= s1VPos;
        o_Colour      <= nextColour;
    end

endmodule

`default_nettype wire

//--- verilog/vgaSubsystem.sv
`default_nettype none

module vgaSubsystem #(
    parameter int HorActive      = 640,  // must be a multiple of 8
    parameter int HorFrontPorch  = 16,
    parameter int HorSync        = 96,
    parameter int HorBackPorch   = 48,
    parameter int VertActive     = 480,
    parameter int VertFrontPorch = 10,
    parameter int VertSync       = 2,
    parameter int VertBackPorch  = 33
) (
    input wire logic                         i_VidClk,
    input wire logic                         i_arstN,
    input wire logic [1:0]                   i_PatMode,
    input wire logic [15:0]                  i_SolidColour,
    input wire logic [15:0]                  i_Colour,    // colour for o_HPos/o_VPos, next cycle
    output logic     [vidPkg::PosWidth-1:0]  o_HPos,
    output logic     [vidPkg::PosWidth-1:0]  o_VPos,
    output logic     [4:0]                   o_R,
    output logic     [5:0]                   o_G,
    output logic     [4:0]                   o_B,
    output logic                             o_nBlank,
    output logic                             o_HSync,
    output logic                             o_VSync,
    output logic                             o_InVBlank
);

    vidTimingIf rawTiming ();   // straight from the counters
    vidTimingIf dlyTiming ();   // two cycles later, beside the colour

    vidPkg::rgb565_t pixColour;

    vidTimingGen #(
        .HorActive      (HorActive),
        .HorFrontPorch  (HorFrontPorch),
        .HorSync        (HorSync),
        .HorBackPorch   (HorBackPorch),
        .VertActive     (VertActive),
        .VertFrontPorch (VertFrontPorch),
        .VertSync       (VertSync),
        .VertBackPorch  (VertBackPorch)
    ) timingGen0 (
        .i_VidClk (i_VidClk),
        .i_arstN  (i_arstN),
        .o_Timing (rawTiming.timing)
    );

    patternGen #(
        .HorActive (HorActive)
    ) patternGen0 (
        .i_VidClk      (i_VidClk),
        .i_arstN       (i_arstN),
        .i_Timing      (rawTiming.sink),
        .o_Timing      (dlyTiming.timing),
        .i_PatMode     (vidPkg::patMode_e'(i_PatMode)),
        .i_SolidColour (i_SolidColour),
        .i_Colour      (i_Colour),
        .o_Colour      (pixColour)
    );

    dacOutStage dacOut0 (
        .i_VidClk   (i_VidClk),
        .i_arstN    (i_arstN),
        .i_Timing   (dlyTiming.sink),
        .i_Colour   (pixColour),
        .o_R        (o_R),
        .o_G        (o_G),
        .o_B        (o_B),
        .o_nBlank   (o_nBlank),
        .o_HSync    (o_HSync),
        .o_VSync    (o_VSync),
        .o_InVBlank (o_InVBlank)
    );

    // position the user looks up in the frame store
    assign o_HPos = rawTiming.hPos;
    assign o_VPos = rawTiming.vPos;

endmodule

`default_nettype wire

//--- verilog/vidPkg.sv
`default_nettype none

package vidPkg;

    // raster position counters, enough for totals up to 2047
    localparam int PosWidth = 11;

    // colour source selection
    typedef enum logic [1:0] {
        patSolid      = 2'd0,   // one latched colour over the whole frame
        patColourBars = 2'd1,   // eight vertical bars
        patGradient   = 2'd2,   // colour follows raster position
        patExternal   = 2'd3    // pixel supplied by the user frame store
    } patMode_e;

    // RGB565 as seen on the DAC pins, red in the top bits
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // classic bar order, full intensity down to black
    localparam rgb565_t BarColours [8] = '{
        16'hFFFF,   // white
        16'hFFE0,   // yellow
        16'h07FF,   // cyan
        16'h07E0,   // green
        16'hF81F,   // magenta
        16'hF800,   // red
        16'h001F,   // blue
        16'h0000    // black
    };

endpackage

`default_nettype wire

//--- verilog/vidTimingGen.sv
`default_nettype none

module vidTimingGen #(
    parameter int HorActive      = 640,
    parameter int HorFrontPorch  = 16,
    parameter int HorSync        = 96,
    parameter int HorBackPorch   = 48,
    parameter int VertActive     = 480,
    parameter int VertFrontPorch = 10,
    parameter int VertSync       = 2,
    parameter int VertBackPorch  = 33
) (
    input wire logic    i_VidClk,
    input wire logic    i_arstN,
    vidTimingIf.timing  o_Timing
);

    localparam int W = vidPkg::PosWidth;

    localparam int HorTotal  = HorActive + HorFrontPorch + HorSync + HorBackPorch;
    localparam int VertTotal = VertActive + VertFrontPorch + VertSync + VertBackPorch;

    localparam logic [W-1:0] HorLast       = W'(HorTotal - 1);
    localparam logic [W-1:0] VertLast      = W'(VertTotal - 1);
    localparam logic [W-1:0] HorActEnd     = W'(HorActive);
    localparam logic [W-1:0] VertActEnd    = W'(VertActive);
    localparam logic [W-1:0] HorSyncStart  = W'(HorActive + HorFrontPorch);
    localparam logic [W-1:0] HorSyncEnd    = W'(HorActive + HorFrontPorch + HorSync);
    localparam logic [W-1:0] VertSyncStart = W'(VertActive + VertFrontPorch);
    localparam logic [W-1:0] VertSyncEnd   = W'(VertActive + VertFrontPorch + VertSync);

    logic [W-1:0] hPos;
    logic [W-1:0] vPos;
    logic [W-1:0] nextHPos;
    logic [W-1:0] nextVPos;
    logic         lineEnd;

    // next raster position
    always_comb begin
        lineEnd  = (hPos == HorLast);
        nextHPos = lineEnd ? '0 : hPos + 1'b1;
        nextVPos = vPos;
        if (lineEnd) begin
            nextVPos = (vPos == VertLast) ? '0 : vPos + 1'b1;
        end
    end

    // flags are decoded from the next position so they line up with the counters
    always_ff @(posedge i_VidClk or negedge i_arstN) begin
        if (!i_arstN) begin
            hPos                <= '0;
            vPos                <= '0;
            o_Timing.active     <= 1'b1;    // decode of pixel 0,0
            o_Timing.hSync      <= 1'b0;
            o_Timing.vSync      <= 1'b0;
            o_Timing.inVBlank   <= 1'b0;
            o_Timing.frameStart <= 1'b1;
        end else begin
            hPos                <= nextHPos;
            vPos                <= nextVPos;
            o_Timing.active     <= (nextHPos < HorActEnd) && (nextVPos < VertActEnd);
            o_Timing.hSync      <= (nextHPos >= HorSyncStart) && (nextHPos < HorSyncEnd);
            o_Timing.vSync      <= (nextVPos >= VertSyncStart) && (nextVPos < VertSyncEnd);
            o_Timing.inVBlank   <= (nextVPos >= VertActEnd);
            o_Timing.frameStart <= (nextHPos == '0) && (nextVPos == '0);
        end
    end

    assign o_Timing.hPos = hPos;
    assign o_Timing.vPos = vPos;

endmodule

`default_nettype wire

//--- verilog/vidTimingIf.sv
`default_nettype none

// one pixel's worth of raster timing, all fields describe the same pixel
interface vidTimingIf;

    logic [vidPkg::PosWidth-1:0] hPos;
    logic [vidPkg::PosWidth-1:0] vPos;
    logic                        active;     // inside the visible area
    logic                        hSync;      // active high over the sync window
    logic                        vSync;
    logic                        inVBlank;   // on a line below the visible area
    logic                        frameStart; // first pixel of a frame

    // driving side
    modport timing (
        output hPos, vPos, active, hSync, vSync, inVBlank, frameStart
    );

    // receiving side
    modport sink (
        input hPos, vPos, active, hSync, vSync, inVBlank, frameStart
    );

endinterface

`default_nettype wire
